//--- src/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

  // clk cycles per quarter of an scl bit, 4 quarters per bit
  localparam int scl_quarter = 2;

  // bus phase requested from the bit engine
  localparam logic [1:0] phase_start   = 2'd0;
  localparam logic [1:0] phase_stop    = 2'd1;
  localparam logic [1:0] phase_tx      = 2'd2; // byte out, ack slot released
  localparam logic [1:0] phase_rx_nack = 2'd3; // byte in, master nack

  localparam logic [3:0] ctrl_prefix = 4'b1010; // 24cxx device type code

  // one-hot sequencer states
  localparam logic [9:0] st_idle        = 10'b00_0000_0001;
  localparam logic [9:0] st_write_start = 10'b00_0000_0010;
  localparam logic [9:0] st_ctrl_write  = 10'b00_0000_0100;
  localparam logic [9:0] st_addr_write  = 10'b00_0000_1000;
  localparam logic [9:0] st_data_write  = 10'b00_0001_0000;
  localparam logic [9:0] st_read_start  = 10'b00_0010_0000;
  localparam logic [9:0] st_ctrl_read   = 10'b00_0100_0000;
  localparam logic [9:0] st_data_read   = 10'b00_1000_0000;
  localparam logic [9:0] st_stop        = 10'b01_0000_0000;
  localparam logic [9:0] st_ackn        = 10'b10_0000_0000;

  // 2 Kbyte array address
  // the block bits sit in the control byte, the low byte is the word address
  typedef union packed {
    logic [10:0] flat;
    struct packed {
      logic [2:0] block;
      logic [7:0] word;
    } bw;
  } eeprom_addr_u;

endpackage

`default_nettype wire

//--- src/eeprom_cmd_seq.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_cmd_seq (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr,
  input  logic        rd,
  input  logic [10:0] addr,
  input  logic [7:0]  wdata,
  input  logic        phase_done,
  input  logic [7:0]  rx_byte,
  output logic        phase_go,
  output logic [1:0]  phase,
  output logic [7:0]  tx_byte,
  output logic        ack,
  output logic [7:0]  rdata,
  output logic        rdata_en
);

  logic [9:0]               state;
  logic                     waiting;  // phase issued, engine still busy
  logic                     is_read;
  eeprom_pkg::eeprom_addr_u addr_q;
  logic [7:0]               wdata_q;
  logic                     strobe;

  assign strobe = (state == eeprom_pkg::st_idle) && (wr || rd);

  // one phase per state, go only while not waiting
  assign phase_go = !waiting
                    && (state != eeprom_pkg::st_idle)
                    && (state != eeprom_pkg::st_ackn);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= eeprom_pkg::st_idle;
      waiting <= 1'b0;
      is_read <= 1'b0;
    end else begin
      waiting <= phase_go || (waiting && !phase_done);
      case (state)
        eeprom_pkg::st_idle: begin
          if (wr) begin            // wr wins over rd
            state   <= eeprom_pkg::st_write_start;
            is_read <= 1'b0;
          end else if (rd) begin
            state   <= eeprom_pkg::st_write_start;
            is_read <= 1'b1;
          end
        end
        eeprom_pkg::st_write_start:
          if (phase_done) state <= eeprom_pkg::st_ctrl_write;
        eeprom_pkg::st_ctrl_write:
          if (phase_done) state <= eeprom_pkg::st_addr_write;
        eeprom_pkg::st_addr_write: begin
          // random read turns around with a repeated start here
          if (phase_done) begin
            state <= is_read ? eeprom_pkg::st_read_start : eeprom_pkg::st_data_write;
          end
        end
        eeprom_pkg::st_data_write:
          if (phase_done) state <= eeprom_pkg::st_stop;
        eeprom_pkg::st_read_start:
          if (phase_done) state <= eeprom_pkg::st_ctrl_read;
        eeprom_pkg::st_ctrl_read:
          if (phase_done) state <= eeprom_pkg::st_data_read;
        eeprom_pkg::st_data_read:
          if (phase_done) state <= eeprom_pkg::st_stop;
        eeprom_pkg::st_stop:
          if (phase_done) state <= eeprom_pkg::st_ackn;
        eeprom_pkg::st_ackn:
          state <= eeprom_pkg::st_idle;  // single ack cycle
        default:
          state <= eeprom_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (strobe) addr_q.flat <= addr;
    if (strobe && wr) wdata_q <= wdata;
    if ((state == eeprom_pkg::st_data_read) && phase_done) rdata <= rx_byte;
  end

  always_comb begin
    case (state)
      eeprom_pkg::st_write_start,
      eeprom_pkg::st_read_start: phase = eeprom_pkg::phase_start;
      eeprom_pkg::st_stop:       phase = eeprom_pkg::phase_stop;
      eeprom_pkg::st_data_read:  phase = eeprom_pkg::phase_rx_nack;
      default:                   phase = eeprom_pkg::phase_tx;
    endcase
  end

  // control byte is prefix, block, r/w bit
  always_comb begin
    case (state)
      eeprom_pkg::st_ctrl_write: tx_byte = {eeprom_pkg::ctrl_prefix, addr_q.bw.block, 1'b0};
      eeprom_pkg::st_ctrl_read:  tx_byte = {eeprom_pkg::ctrl_prefix, addr_q.bw.block, 1'b1};
      eeprom_pkg::st_addr_write: tx_byte = addr_q.bw.word;
      eeprom_pkg::st_data_write: tx_byte = wdata_q;
      default:                   tx_byte = 8'h00;
    endcase
  end

  assign ack      = (state == eeprom_pkg::st_ackn);
  assign rdata_en = ack && is_read;  // read byte shown in the ack cycle

endmodule

`default_nettype wire

//--- src/eeprom_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_bit_engine (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       phase_go,
  input  logic [1:0] phase,
  input  logic [7:0] tx_byte,
  input  logic       sda_in,
  output logic       phase_done,
  output logic [7:0] rx_byte,
  output logic       scl,
  output logic       sda_low
);

  logic                                       busy;
  logic [$clog2(eeprom_pkg::scl_quarter)-1:0] qcnt;     // clk within a quarter
  logic [1:0]                                 quarter;  // quarter within a bit
  logic [3:0]                                 bit_cnt;  // 0..8, bit 8 is the ack slot
  logic [7:0]                                 sh_out;
  logic [7:0]                                 sh_in;
  logic                                       q_end;
  logic                                       bit_end;
  logic                                       short_phase;
  logic                                       sample;
  logic                                       scl_now;
  logic                                       low_now;
  logic                                       scl_hold;
  logic                                       low_hold;

  assign q_end = busy && (qcnt == $bits(qcnt)'(eeprom_pkg::scl_quarter - 1));
  assign bit_end = q_end && (quarter == 2'd3);

  // start and stop are one bit time, tx and rx are nine
  assign short_phase = (phase == eeprom_pkg::phase_start)
                       || (phase == eeprom_pkg::phase_stop);
  assign phase_done = bit_end && (short_phase || (bit_cnt == 4'd8));

  // middle of scl high is the end of quarter 1
  assign sample = q_end && (quarter == 2'd1)
                  && (phase == eeprom_pkg::phase_rx_nack)
                  && (bit_cnt != 4'd8);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      qcnt     <= '0;
      quarter  <= 2'd0;
      bit_cnt  <= 4'd0;
      scl_hold <= 1'b1;  // bus idle, scl high and sda released
      low_hold <= 1'b0;
    end else if (phase_go) begin
      busy    <= 1'b1;
      qcnt    <= '0;
      quarter <= 2'd0;
      bit_cnt <= 4'd0;
    end else if (busy) begin
      // keep the last driven levels for the gap between phases
      scl_hold <= scl_now;
      low_hold <= low_now;
      qcnt     <= q_end ? '0 : qcnt + 1'b1;
      if (q_end) quarter <= quarter + 2'd1;
      if (bit_end) bit_cnt <= bit_cnt + 4'd1;
      if (phase_done) busy <= 1'b0;
    end
  end

  // shift-out MSB first, shift-in MSB first
  always_ff @(posedge clk) begin
    if (phase_go) begin
      sh_out <= tx_byte;
    end else if (bit_end) begin
      sh_out <= {sh_out[6:0], 1'b0};
    end
    if (sample) sh_in <= {sh_in[6:0], sda_in};
  end

  assign rx_byte = sh_in;

  always_comb begin
    scl_now = (quarter == 2'd1) || (quarter == 2'd2);  // high in the middle quarters
    low_now = 1'b0;
    case (phase)
      eeprom_pkg::phase_start: begin
        // sda falls while scl is high
        low_now = quarter[1];
      end
      eeprom_pkg::phase_stop: begin
        // scl stays high at the end, sda rises while scl is high
        scl_now = (quarter != 2'd0);
        low_now = !quarter[1];
      end
      eeprom_pkg::phase_tx: begin
        low_now = (bit_cnt != 4'd8) && !sh_out[7];  // ack slot released
      end
      default: begin
        low_now = 1'b0;  // released for data, nack is a released line
      end
    endcase
  end

  assign scl     = busy ? scl_now : scl_hold;
  assign sda_low = busy ? low_now : low_hold;

endmodule

`default_nettype wire

//--- src/eeprom_wr.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_wr (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        wr,
  input  wire        rd,
  input  wire [10:0] addr,
  inout  wire [7:0]  data,
  inout  wire        sda,
  output logic       ack,
  output logic       scl
);

  logic       phase_go;
  logic [1:0] phase;
  logic [7:0] tx_byte;
  logic       phase_done;
  logic [7:0] rx_byte;
  logic [7:0] rdata;
  logic       rdata_en;
  logic       sda_low;

  eeprom_cmd_seq u_cmd_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr         (wr),
    .rd         (rd),
    .addr       (addr),
    .wdata      (data),
    .phase_done (phase_done),
    .rx_byte    (rx_byte),
    .phase_go   (phase_go),
    .phase      (phase),
    .tx_byte    (tx_byte),
    .ack        (ack),
    .rdata      (rdata),
    .rdata_en   (rdata_en)
  );

  eeprom_bit_engine u_bit_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase_go   (phase_go),
    .phase      (phase),
    .tx_byte    (tx_byte),
    .sda_in     (sda),
    .phase_done (phase_done),
    .rx_byte    (rx_byte),
    .scl        (scl),
    .sda_low    (sda_low)
  );

  assign sda  = sda_low ? 1'b0 : 1'bz;     // open drain, pull-up outside
  assign data = rdata_en ? rdata : 8'hzz;  // host bus driven only in read ack

endmodule

`default_nettype wire

//--- sim/eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
  input wire scl,
  inout wire sda
);

  logic [7:0]  mem [0:2047];
  logic [7:0]  last_ctrl;
  logic [7:0]  shreg;
  logic [10:0] ptr;
  logic        drive_low;
  logic        active;
  logic        sending;  // slave shifting a byte out
  logic        acking;
  logic        reading;
  int          bit_cnt;
  int          byte_idx;

  assign sda = drive_low ? 1'b0 : 1'bz;

  initial begin
    for (int i = 0; i < 2048; i++) begin
      mem[i] = 8'(i * 37 + (i >> 8));
    end
    drive_low = 1'b0;
    active    = 1'b0;
    sending   = 1'b0;
    acking    = 1'b0;
    reading   = 1'b0;
    bit_cnt   = 0;
    byte_idx  = 0;
    ptr       = '0;
    last_ctrl = '0;
  end

  task automatic take_byte();
    case (byte_idx)
      0: begin
        last_ctrl = shreg;
        ptr[10:8] = shreg[3:1];  // block bits
        reading   = shreg[0];
      end
      1:       ptr[7:0] = shreg;
      default: mem[ptr] = shreg;
    endcase
    byte_idx++;
  endtask

  // start or repeated start
  always @(negedge sda) begin
    if (scl === 1'b1) begin
      active   = 1'b1;
      sending  = 1'b0;
      acking   = 1'b0;
      bit_cnt  = 0;
      byte_idx = 0;
    end
  end

  always @(posedge sda) begin
    if (scl === 1'b1) begin  // stop
      active    = 1'b0;
      drive_low = 1'b0;
    end
  end

  always @(posedge scl) begin
    if (active && !acking) begin
      if (!sending && bit_cnt < 8) begin
        shreg = {shreg[6:0], sda};
        bit_cnt++;
        if (bit_cnt == 8) take_byte();
      end else if (sending) begin
        bit_cnt++;  // master samples, last clock is its nack
      end
    end
  end

  always @(negedge scl) begin
    if (active) begin
      if (acking) begin
        acking    = 1'b0;
        bit_cnt   = 0;
        drive_low = 1'b0;
        if (reading && byte_idx == 1) begin
          sending   = 1'b1;
          shreg     = mem[ptr];
          drive_low = !shreg[7];
        end
      end else if (!sending && bit_cnt == 8) begin
        acking    = 1'b1;
        drive_low = 1'b1;
      end else if (sending) begin
        drive_low = (bit_cnt < 8) ? !shreg[7 - bit_cnt] : 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_eeprom_wr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_wr;

  logic        clk;
  logic        rst_n;
  logic        wr;
  logic        rd;
  logic [10:0] addr;
  logic [7:0]  host_data;
  logic        host_oe;
  wire  [7:0]  data;
  wire         sda;
  wire         scl;
  wire         ack;
  int          errors;
  int          tests;
  logic [7:0]  shadow [0:2047];
  logic [10:0] rand_addr [0:7];

  assign data = host_oe ? host_data : 8'hzz;
  pullup (sda);

  eeprom_wr u_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .rd    (rd),
    .addr  (addr),
    .data  (data),
    .sda   (sda),
    .ack   (ack),
    .scl   (scl)
  );

  eeprom_model u_model (
    .scl (scl),
    .sda (sda)
  );

  always #10 clk = ~clk;

  task automatic check_bit(input logic exp, input logic got, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, expected %b got %b", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_byte(input logic [7:0] exp, input logic [7:0] got, input string what);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, expected %h got %h", $time, what, exp, got);
      errors++;
    end
  endtask

  task automatic check_ctrl(input eeprom_pkg::eeprom_addr_u a, input logic rw);
    logic [7:0] exp;
    exp = {4'b1010, a.bw.block, rw};
    if (u_model.last_ctrl !== exp) begin
      $display("FAIL at %0t ns: control byte for %h, expected %h got %h",
               $time, a.flat, exp, u_model.last_ctrl);
      errors++;
    end
  endtask

  task automatic wait_ack(output logic [7:0] got);
    int n;
    n = 0;
    @(negedge clk);
    while (ack !== 1'b1 && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (ack !== 1'b1) begin
      $display("timeout: the controller gave no ack within 2000 cycles");
      $display("Test failed");
      $finish;
    end else begin
      got = data;  // read byte is valid in the ack cycle
    end
  endtask

  task automatic strobe(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
    @(posedge clk);
    wr        <= is_wr;
    rd        <= !is_wr;
    addr      <= a;
    host_data <= d;
    host_oe   <= is_wr;
    @(posedge clk);
    wr      <= 1'b0;
    rd      <= 1'b0;
    host_oe <= 1'b0;
  endtask

  task automatic write_byte(input logic [10:0] a, input logic [7:0] d);
    logic [7:0] got;
    strobe(1'b1, a, d);
    wait_ack(got);
  endtask

  task automatic read_byte(input logic [10:0] a, output logic [7:0] got);
    strobe(1'b0, a, 8'h00);
    wait_ack(got);
  endtask

  task automatic test_done(input string name);
    tests++;
    $display("test %s done, %0d errors so far", name, errors);
  endtask

  task automatic test_reset();
    repeat (20) begin
      @(negedge clk);
      check_bit(1'b0, ack, "ack after reset");
      check_bit(1'b1, scl, "scl after reset");
      check_bit(1'b1, sda, "sda after reset");
      check_byte(8'hzz, data, "data bus after reset");
    end
    test_done("reset state");
  endtask

  task automatic test_write_read();
    logic [7:0] got;
    write_byte(11'h123, 8'h5a);
    read_byte(11'h123, got);
    check_byte(8'h5a, got, "read back");
    test_done("write then read");
  endtask

  task automatic test_block_decode();
    eeprom_pkg::eeprom_addr_u a;
    logic [7:0]               got;
    for (int b = 0; b < 8; b += 7) begin
      a.bw.block = 3'(b);
      a.bw.word  = 8'h47 + 8'(b);
      write_byte(a.flat, 8'ha0 + 8'(b));
      check_ctrl(a, 1'b0);
      read_byte(a.flat, got);
      check_ctrl(a, 1'b1);
      check_byte(8'ha0 + 8'(b), got, "block read back");
    end
    test_done("block decode");
  endtask

  task automatic test_busy_strobe();
    logic [7:0] got;
    int         acks;
    write_byte(11'h2f0, 8'hc3);
    strobe(1'b1, 11'h155, 8'h3c);
    repeat (30) @(posedge clk);
    wr        <= 1'b1;  // arrives mid transaction
    addr      <= 11'h2f0;
    host_data <= 8'h99;
    host_oe   <= 1'b1;
    @(posedge clk);
    wr      <= 1'b0;
    host_oe <= 1'b0;
    wait_ack(got);
    acks = 0;
    repeat (400) begin
      @(negedge clk);
      if (ack) acks++;
    end
    check_bit(1'b0, acks != 0, "extra ack after busy strobe");
    read_byte(11'h2f0, got);
    check_byte(8'hc3, got, "address of ignored strobe");
    read_byte(11'h155, got);
    check_byte(8'h3c, got, "busy write target");
    test_done("busy strobe ignored");
  endtask

  task automatic test_random();
    logic [7:0] d;
    logic [7:0] got;
    for (int i = 0; i < 8; i++) begin
      rand_addr[i] = 11'($urandom);
      d = 8'($urandom);
      shadow[rand_addr[i]] = d;
      write_byte(rand_addr[i], d);
    end
    for (int i = 7; i >= 0; i--) begin
      read_byte(rand_addr[i], got);
      check_byte(shadow[rand_addr[i]], got, "random read back");
    end
    test_done("random sequence");
  endtask

  initial begin
    void'($urandom(25));
    clk       = 1'b0;
    rst_n     = 1'b0;
    wr        = 1'b0;
    rd        = 1'b0;
    addr      = '0;
    host_data = '0;
    host_oe   = 1'b0;
    errors    = 0;
    tests     = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_write_read();
    test_block_decode();
    test_busy_strobe();
    test_random();
    $display("summary: %0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
src/eeprom_pkg.sv
src/eeprom_cmd_seq.sv
src/eeprom_bit_engine.sv
src/eeprom_wr.sv
sim/eeprom_model.sv
sim/tb_eeprom_wr.sv
